/* mac_tx_consts.svh */
`ifndef MAC_TX_CONSTS_SVH
`define MAC_TX_CONSTS_SVH

// Frame layout on the wire.
`define MAC_PREAMBLE_LEN  7
`define MAC_PREAMBLE_BYTE 8'h55
`define MAC_SFD           8'hD5
`define MAC_HDR_LEN       22

// Payload and trailer sizes in bytes.
`define MAC_MIN_PAYLOAD   46
`define MAC_MAX_PAYLOAD   1500
`define MAC_FCS_LEN       4

// Reflected CRC-32 as used by the Ethernet FCS.
`define CRC32_POLY_REFL   32'hEDB88320
`define CRC32_INIT        32'hFFFFFFFF

`define PAYLOAD_FIFO_DEPTH 2048

`endif

/* mac_tx_pkg.sv */
`default_nettype none

package mac_tx_pkg;

  // Byte 5 goes out first.
  typedef logic [5:0][7:0] mac_addr_t;

  // High byte goes out first.
  typedef logic [15:0] ethertype_t;

  // Payload length in bytes, 1 to 1500.
  typedef logic [10:0] length_t;

  // Wraps at 16 bits.
  typedef logic [15:0] frame_cnt_t;

  typedef enum logic [2:0] {
    idle_s,
    hdr_s,
    pld_s,
    pad_s,
    fcs_s
  } tx_state_t;

endpackage : mac_tx_pkg

`default_nettype wire

/* crc32_gen.sv */
`default_nettype none

`include "mac_tx_consts.svh"

module crc32_gen (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        clr,
  input  logic        en,
  input  logic [7:0]  data,
  output logic [31:0] crc
);

  logic [31:0] crc_next;

  // One byte per cycle, LSB of the byte first.
  always_comb begin : byte_step
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ `CRC32_POLY_REFL;
      end else begin
        c = c >> 1;
      end
    end
    crc_next = c;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      crc <= `CRC32_INIT;
    end else if (clr) begin
      crc <= `CRC32_INIT;
    end else if (en) begin
      crc <= crc_next;
    end
  end

  // The framer clears on accept and feeds bytes only later.
  a_clr_en_excl : assert property (@(posedge clk) disable iff (fsm_rst)
    !(clr && en));

endmodule : crc32_gen

`default_nettype wire

/* payload_fifo.sv */
`default_nettype none

`include "mac_tx_consts.svh"

module payload_fifo #(
  parameter int unsigned DEPTH = `PAYLOAD_FIFO_DEPTH
)(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       wr,
  input  logic [7:0] wr_data,
  input  logic       rd,
  output logic [7:0] rd_data,
  output logic       empty,
  output logic       full
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_wr;
  logic        do_rd;

  // Top pointer bit tells a full buffer from an empty one.
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;

  // Show-ahead: head byte is always on the output.
  assign rd_data = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1;
      end
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (fsm_rst)
    wr |-> !full);

  // Fires when a frame asks for more payload than was loaded.
  a_no_underflow : assert property (@(posedge clk) disable iff (fsm_rst)
    rd |-> !empty);

endmodule : payload_fifo

`default_nettype wire

/* mac_tx_cfg.sv */
`default_nettype none

module mac_tx_cfg (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   cfg_wr,
  input  mac_tx_pkg::mac_addr_t  cfg_mac_addr,
  input  logic                   cfg_tx_en,
  input  logic                   frame_sent,
  output mac_tx_pkg::mac_addr_t  local_mac,
  output logic                   tx_en,
  output mac_tx_pkg::frame_cnt_t frames_sent
);

  import mac_tx_pkg::*;

  // ======================================================================
  // Software registers
  // ======================================================================

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      local_mac <= '0;
      tx_en     <= 1'b0;
    end else if (cfg_wr) begin
      local_mac <= cfg_mac_addr;
      tx_en     <= cfg_tx_en;
    end
  end

  // ======================================================================
  // Status
  // ======================================================================

  // One count per tx_done pulse, wrapping.
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      frames_sent <= '0;
    end else if (frame_sent) begin
      frames_sent <= frames_sent + frame_cnt_t'(1);
    end
  end

endmodule : mac_tx_cfg

`default_nettype wire

/* mac_tx_framer.sv */
`default_nettype none

`include "mac_tx_consts.svh"

module mac_tx_framer (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   tx_en,
  input  mac_tx_pkg::mac_addr_t  local_mac,
  input  logic                   tx_rdy,
  input  mac_tx_pkg::mac_addr_t  tx_dst,
  input  mac_tx_pkg::ethertype_t tx_ethertype,
  input  mac_tx_pkg::length_t    tx_len,
  output logic                   tx_acc,
  output logic                   tx_done,
  output logic                   pld_rd,
  input  logic [7:0]             pld_data,
  output logic                   crc_clr,
  output logic                   crc_en,
  output logic [7:0]             crc_byte,
  input  logic [31:0]            crc,
  output logic                   phy_val,
  output logic [7:0]             phy_dat
);

  import mac_tx_pkg::*;

  localparam int HDR_CNT_W = $clog2(`MAC_HDR_LEN);

  localparam logic [HDR_CNT_W-1:0] HDR_LAST  = HDR_CNT_W'(`MAC_HDR_LEN - 1);
  // First byte after the SFD, where the CRC starts.
  localparam logic [HDR_CNT_W-1:0] CRC_START = HDR_CNT_W'(`MAC_PREAMBLE_LEN + 1);
  localparam length_t              MIN_LAST  = length_t'(`MAC_MIN_PAYLOAD - 1);
  localparam logic [2:0]           FCS_END   = 3'(`MAC_FCS_LEN);

  tx_state_t state;

  logic [`MAC_HDR_LEN-1:0][7:0] hdr_sr;
  logic [HDR_CNT_W-1:0]         hdr_cnt;
  length_t                      cur_len;
  length_t                      data_cnt;
  logic [2:0]                   fcs_cnt;

  logic [3:0][7:0] crc_inv;
  logic            accept;
  logic            hdr_step;
  logic            emit;
  logic [7:0]      tx_byte;

  // ======================================================================
  // Byte selection
  // ======================================================================

  assign accept   = (state == idle_s) && tx_rdy && tx_en;
  // The accept cycle itself sends nothing.
  assign hdr_step = (state == hdr_s) && !tx_acc;

  assign emit = hdr_step || (state == pld_s) || (state == pad_s) ||
                ((state == fcs_s) && (fcs_cnt != FCS_END));

  assign crc_inv = ~crc;

  always_comb begin
    case (state)
      hdr_s:   tx_byte = hdr_sr[`MAC_HDR_LEN-1];
      pld_s:   tx_byte = pld_data;
      fcs_s:   tx_byte = crc_inv[fcs_cnt[1:0]];
      default: tx_byte = 8'h00;
    endcase
  end

  assign pld_rd   = (state == pld_s);
  assign crc_clr  = tx_acc;
  assign crc_en   = (hdr_step && (hdr_cnt >= CRC_START)) ||
                    (state == pld_s) || (state == pad_s);
  assign crc_byte = tx_byte;

  // ======================================================================
  // FSM
  // ======================================================================

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= idle_s;
      tx_acc   <= 1'b0;
      tx_done  <= 1'b0;
      phy_val  <= 1'b0;
      hdr_cnt  <= '0;
      data_cnt <= '0;
      fcs_cnt  <= '0;
    end else begin
      tx_acc  <= accept;
      tx_done <= 1'b0;
      phy_val <= emit;
      case (state)
        idle_s: begin
          if (accept) begin
            state   <= hdr_s;
            hdr_cnt <= '0;
          end
        end
        hdr_s: begin
          if (hdr_step) begin
            hdr_cnt <= hdr_cnt + 1;
            if (hdr_cnt == HDR_LAST) begin
              state    <= pld_s;
              data_cnt <= '0;
            end
          end
        end
        pld_s: begin
          data_cnt <= data_cnt + 1;
          if (data_cnt == cur_len - 1) begin
            fcs_cnt <= '0;
            state   <= (data_cnt >= MIN_LAST) ? fcs_s : pad_s;
          end
        end
        pad_s: begin
          data_cnt <= data_cnt + 1;
          if (data_cnt == MIN_LAST) begin
            fcs_cnt <= '0;
            state   <= fcs_s;
          end
        end
        fcs_s: begin
          // Extra cycle after the last byte lets phy_val fall first.
          if (fcs_cnt == FCS_END) begin
            state   <= idle_s;
            tx_done <= 1'b1;
          end else begin
            fcs_cnt <= fcs_cnt + 1;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cur_len <= tx_len;
      hdr_sr  <= {{`MAC_PREAMBLE_LEN{`MAC_PREAMBLE_BYTE}}, `MAC_SFD,
                  tx_dst, local_mac, tx_ethertype};
    end else if (hdr_step) begin
      hdr_sr <= {hdr_sr[`MAC_HDR_LEN-2:0], 8'h00};
    end
    if (emit) begin
      phy_dat <= tx_byte;
    end
  end

  // ======================================================================
  // Checks
  // ======================================================================

  a_phy_contig : assert property (@(posedge clk) disable iff (fsm_rst)
    (phy_val && !((state == fcs_s) && (fcs_cnt == FCS_END))) |=> phy_val);

  a_len_range : assert property (@(posedge clk) disable iff (fsm_rst)
    accept |-> ((tx_len >= length_t'(1)) && (tx_len <= length_t'(`MAC_MAX_PAYLOAD))));

endmodule : mac_tx_framer

`default_nettype wire

/* mac_tx_top.sv */
`default_nettype none

module mac_tx_top (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   pld_wr,
  input  logic [7:0]             pld_data,
  output logic                   pld_full,
  input  logic                   cfg_wr,
  input  mac_tx_pkg::mac_addr_t  cfg_mac_addr,
  input  logic                   cfg_tx_en,
  input  logic                   tx_rdy,
  input  mac_tx_pkg::mac_addr_t  tx_dst,
  input  mac_tx_pkg::ethertype_t tx_ethertype,
  input  mac_tx_pkg::length_t    tx_len,
  output logic                   tx_acc,
  output logic                   tx_done,
  output mac_tx_pkg::frame_cnt_t frames_sent,
  output logic                   phy_val,
  output logic [7:0]             phy_dat
);

  import mac_tx_pkg::*;

  logic       pld_rd;
  logic [7:0] pld_rd_data;
  logic       pld_empty;

  mac_addr_t  local_mac;
  logic       tx_en;

  logic        crc_clr;
  logic        crc_en;
  logic [7:0]  crc_byte;
  logic [31:0] crc;

  payload_fifo i_payload_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (pld_wr),
    .wr_data (pld_data),
    .rd      (pld_rd),
    .rd_data (pld_rd_data),
    .empty   (pld_empty),
    .full    (pld_full)
  );

  mac_tx_cfg i_mac_tx_cfg (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .cfg_wr       (cfg_wr),
    .cfg_mac_addr (cfg_mac_addr),
    .cfg_tx_en    (cfg_tx_en),
    .frame_sent   (tx_done),
    .local_mac    (local_mac),
    .tx_en        (tx_en),
    .frames_sent  (frames_sent)
  );

  mac_tx_framer i_mac_tx_framer (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .tx_en        (tx_en),
    .local_mac    (local_mac),
    .tx_rdy       (tx_rdy),
    .tx_dst       (tx_dst),
    .tx_ethertype (tx_ethertype),
    .tx_len       (tx_len),
    .tx_acc       (tx_acc),
    .tx_done      (tx_done),
    .pld_rd       (pld_rd),
    .pld_data     (pld_rd_data),
    .crc_clr      (crc_clr),
    .crc_en       (crc_en),
    .crc_byte     (crc_byte),
    .crc          (crc),
    .phy_val      (phy_val),
    .phy_dat      (phy_dat)
  );

  crc32_gen i_crc32_gen (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (crc_clr),
    .en      (crc_en),
    .data    (crc_byte),
    .crc     (crc)
  );

  // Payload is loaded before the request, so the FIFO holds data at accept.
  a_pld_loaded : assert property (@(posedge clk) disable iff (fsm_rst)
    tx_acc |-> !pld_empty);

endmodule : mac_tx_top

`default_nettype wire

/* mac_tx_tb.sv */
`default_nettype none

`include "mac_tx_consts.svh"

module mac_tx_tb;

  import mac_tx_pkg::*;

  typedef logic [7:0] byte_q_t[$];

  localparam int HALF_PERIOD  = 20;
  localparam int DRIVE_DLY    = 4;
  localparam int ACC_TIMEOUT  = 100;
  localparam int DONE_TIMEOUT = 4000;
  localparam int BURST_FRAMES = 5;
  localparam int SRC_FIRST    = `MAC_PREAMBLE_LEN + 7;
  localparam int SRC_LAST     = SRC_FIRST + 5;

  logic       clk;
  logic       fsm_rst;
  logic       pld_wr;
  logic [7:0] pld_data;
  logic       pld_full;
  logic       cfg_wr;
  mac_addr_t  cfg_mac_addr;
  logic       cfg_tx_en;
  logic       tx_rdy;
  mac_addr_t  tx_dst;
  ethertype_t tx_ethertype;
  length_t    tx_len;
  logic       tx_acc;
  logic       tx_done;
  frame_cnt_t frames_sent;
  logic       phy_val;
  logic [7:0] phy_dat;

  integer    seed;
  mac_addr_t local_exp;
  byte_q_t   exp_q;
  int        exp_pld_q[$];
  mac_addr_t exp_src_q[$];
  mac_addr_t src_seen;
  int        run_len;
  int        frames_seen;
  int        frames_exp;

  mac_tx_top i_mac_tx_top (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .pld_wr       (pld_wr),
    .pld_data     (pld_data),
    .pld_full     (pld_full),
    .cfg_wr       (cfg_wr),
    .cfg_mac_addr (cfg_mac_addr),
    .cfg_tx_en    (cfg_tx_en),
    .tx_rdy       (tx_rdy),
    .tx_dst       (tx_dst),
    .tx_ethertype (tx_ethertype),
    .tx_len       (tx_len),
    .tx_acc       (tx_acc),
    .tx_done      (tx_done),
    .frames_sent  (frames_sent),
    .phy_val      (phy_val),
    .phy_dat      (phy_dat)
  );

  always #(HALF_PERIOD) clk = ~clk;

  // ======================================================================
  // Error reporting and compare tasks
  // ======================================================================

  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_plain(string what);
    $display("Error at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %02h, expected %02h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_mac(string name, mac_addr_t got, mac_addr_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %012h, expected %012h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_len(string name, length_t got, length_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(string name, frame_cnt_t got, frame_cnt_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ======================================================================
  // Reference model
  // ======================================================================

  function automatic logic [31:0] crc_update(logic [31:0] c, logic [7:0] b);
    logic [31:0] r;
    r = c ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      r = (r >> 1) ^ (`CRC32_POLY_REFL & {32{r[0]}});
    end
    return r;
  endfunction

  function automatic byte_q_t ref_frame(mac_addr_t dst, mac_addr_t src,
                                        ethertype_t et, byte_q_t pld);
    byte_q_t     f;
    logic [31:0] c;
    for (int i = 0; i < `MAC_PREAMBLE_LEN; i++) f.push_back(8'h55);
    f.push_back(8'hD5);
    for (int i = 5; i >= 0; i--) f.push_back(dst[i]);
    for (int i = 5; i >= 0; i--) f.push_back(src[i]);
    f.push_back(et[15:8]);
    f.push_back(et[7:0]);
    foreach (pld[i]) f.push_back(pld[i]);
    for (int i = pld.size(); i < `MAC_MIN_PAYLOAD; i++) f.push_back(8'h00);
    // FCS covers everything after the SFD.
    c = `CRC32_INIT;
    for (int i = `MAC_PREAMBLE_LEN + 1; i < f.size(); i++) c = crc_update(c, f[i]);
    c = ~c;
    for (int i = 0; i < `MAC_FCS_LEN; i++) f.push_back(c[8*i +: 8]);
    return f;
  endfunction

  function automatic byte_q_t make_payload(int len);
    byte_q_t p;
    for (int i = 0; i < len; i++) p.push_back(8'($random(seed)));
    return p;
  endfunction

  // ======================================================================
  // Monitor
  // ======================================================================

  always @(negedge clk) begin : monitor
    if (!fsm_rst && phy_val) begin
      if (exp_q.size() == 0) begin
        fail_plain("PHY byte seen with no frame expected");
      end else begin
        check_byte("phy_dat", phy_dat, exp_q.pop_front());
      end
      if (run_len >= SRC_FIRST && run_len <= SRC_LAST) begin
        src_seen[SRC_LAST - run_len] = phy_dat;
      end
      run_len++;
    end else if (run_len != 0) begin
      // A gap inside a frame splits it and breaks this length.
      check_len("frame payload length", length_t'(run_len - `MAC_HDR_LEN - `MAC_FCS_LEN),
                length_t'(exp_pld_q.pop_front()));
      check_mac("source address", src_seen, exp_src_q.pop_front());
      run_len = 0;
      frames_seen++;
    end
  end

  // ======================================================================
  // Stimulus tasks
  // ======================================================================

  task automatic step();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic load_payload(byte_q_t p);
    foreach (p[i]) begin
      if (pld_full) fail_plain("payload FIFO full during load");
      pld_wr   = 1'b1;
      pld_data = p[i];
      step();
    end
    pld_wr = 1'b0;
  endtask

  task automatic write_cfg(mac_addr_t mac, logic en);
    cfg_wr       = 1'b1;
    cfg_mac_addr = mac;
    cfg_tx_en    = en;
    step();
    cfg_wr    = 1'b0;
    local_exp = mac;
  endtask

  task automatic expect_frame(mac_addr_t dst, ethertype_t et, byte_q_t p);
    byte_q_t f;
    f = ref_frame(dst, local_exp, et, p);
    foreach (f[i]) exp_q.push_back(f[i]);
    exp_pld_q.push_back((p.size() < `MAC_MIN_PAYLOAD) ? `MAC_MIN_PAYLOAD : p.size());
    exp_src_q.push_back(local_exp);
    frames_exp++;
  endtask

  task automatic request(mac_addr_t dst, ethertype_t et, int len);
    tx_dst       = dst;
    tx_ethertype = et;
    tx_len       = length_t'(len);
    tx_rdy       = 1'b1;
  endtask

  task automatic hold_no_acc(int cycles);
    repeat (cycles) begin
      step();
      if (tx_acc) fail_plain("tx_acc pulsed while transmit is disabled");
    end
  endtask

  task automatic finish_frame();
    int   n;
    logic last_val;
    n = 0;
    do begin
      step();
      n++;
    end while (!tx_acc && n < ACC_TIMEOUT);
    if (!tx_acc) fail_plain("no tx_acc within the timeout");
    if (n != 1) fail_plain("tx_acc came later than one cycle after the request");
    // Metadata changes after accept must not reach the frame.
    tx_rdy       = 1'b0;
    tx_dst       = ~tx_dst;
    tx_ethertype = ~tx_ethertype;
    tx_len       = '0;
    step();
    check_bit("tx_acc", tx_acc, 1'b0);
    check_bit("phy_val", phy_val, 1'b0);
    step();
    check_bit("phy_val", phy_val, 1'b1);
    n = 0;
    do begin
      last_val = phy_val;
      step();
      n++;
    end while (!tx_done && n < DONE_TIMEOUT);
    if (!tx_done) fail_plain("no tx_done within the timeout");
    // tx_done rises on the edge where phy_val falls.
    check_bit("phy_val at tx_done", phy_val, 1'b0);
    check_bit("phy_val before tx_done", last_val, 1'b1);
  endtask

  task automatic send_frame(mac_addr_t dst, ethertype_t et, byte_q_t p);
    load_payload(p);
    expect_frame(dst, et, p);
    request(dst, et, p.size());
    finish_frame();
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial begin : stimulus
    byte_q_t    p;
    byte_q_t    q;
    mac_addr_t  dst;
    int         lens[$];
    seed         = 32'hbf966a35;
    clk          = 1'b0;
    fsm_rst      = 1'b1;
    pld_wr       = 1'b0;
    pld_data     = '0;
    cfg_wr       = 1'b0;
    cfg_mac_addr = '0;
    cfg_tx_en    = 1'b0;
    tx_rdy       = 1'b0;
    tx_dst       = '0;
    tx_ethertype = '0;
    tx_len       = '0;
    local_exp    = '0;
    run_len      = 0;
    frames_seen  = 0;
    frames_exp   = 0;
    repeat (4) @(posedge clk);
    #(DRIVE_DLY);
    fsm_rst = 1'b0;
    check_bit("tx_acc", tx_acc, 1'b0);
    check_bit("tx_done", tx_done, 1'b0);
    check_bit("phy_val", phy_val, 1'b0);
    check_count("frames_sent", frames_sent, '0);

    // Request held while disabled, then released by the enable.
    dst = 48'h02_00_00_00_00_01;
    p   = make_payload(20);
    load_payload(p);
    request(dst, 16'h0800, p.size());
    hold_no_acc(ACC_TIMEOUT);
    write_cfg(48'h0a_1b_2c_3d_4e_5f, 1'b1);
    expect_frame(dst, 16'h0800, p);
    finish_frame();

    // Short frame, padded to the minimum.
    send_frame(dst, 16'h88b5, make_payload(10));

    // New source address in the next frame.
    write_cfg(48'h00_11_22_33_44_55, 1'b1);
    send_frame(48'hff_ff_ff_ff_ff_ff, 16'h0806, make_payload(30));

    repeat (3) begin
      send_frame(mac_addr_t'({$random(seed), $random(seed)}), 16'($random(seed)),
                 make_payload(`MAC_MIN_PAYLOAD + {$random(seed)} % 1455));
    end

    // FIFO filled to its depth, then drained by two frames.
    p = make_payload(`MAC_MAX_PAYLOAD);
    q = make_payload(`PAYLOAD_FIFO_DEPTH - `MAC_MAX_PAYLOAD);
    load_payload(p);
    load_payload(q);
    check_bit("pld_full", pld_full, 1'b1);
    expect_frame(dst, 16'h0800, p);
    request(dst, 16'h0800, p.size());
    finish_frame();
    check_bit("pld_full", pld_full, 1'b0);
    expect_frame(dst, 16'h0800, q);
    request(dst, 16'h0800, q.size());
    finish_frame();

    // Back-to-back burst with all payloads loaded up front.
    for (int k = 0; k < BURST_FRAMES; k++) begin
      lens.push_back(1 + {$random(seed)} % 120);
      p = make_payload(lens[k]);
      load_payload(p);
      expect_frame(dst, 16'(k), p);
    end
    foreach (lens[k]) begin
      request(dst, 16'(k), lens[k]);
      finish_frame();
    end
    step();
    check_count("frames_sent", frames_sent, frame_cnt_t'(frames_exp));
    repeat (2) step();
    check_count("frames seen on PHY", frame_cnt_t'(frames_seen), frame_cnt_t'(frames_exp));

    if (exp_q.size() != 0) begin
      fail_plain("expected PHY bytes were never sent");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule : mac_tx_tb

`default_nettype wire

/* filelist.f */
+incdir+.
mac_tx_pkg.sv
crc32_gen.sv
payload_fifo.sv
mac_tx_cfg.sv
mac_tx_framer.sv
mac_tx_top.sv
mac_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mac_tx_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes.
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
